//--- Makefile
TOP := execute_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- testbench/execute_stage_props.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

// checks on the execute controller, seen from the top level ports
module execute_stage_props
    import exec_pkg::*;
(
    input logic                      clk,
    input logic                      arst_n,
    input logic [`EXEC_OPCODE_W-1:0] opcode,
    input logic                      stall_pc,
    input logic [`EXEC_INSTR_W-1:0]  instr_output,
    input logic [1:0]                sel_a_in
);

    // a nop in execute reads nothing, so it never waits on a load
    nop_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
        opcode == `EXEC_OPCODE_NOP |-> !stall_pc)
        else $error("stall_pc high with a nop in execute");

    // bubble goes down while stalled
    stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        stall_pc |-> instr_output == `EXEC_NOP_INSTR)
        else $error("stalled instruction passed to memory stage");

    // pc path on a only for ldr literal or pc-relative branch
    pc_sel_a: assert property (@(posedge clk) disable iff (!arst_n)
        sel_a_in == sel_pc_imm |-> (opcode[6:3] == 4'b1000)
                                || (opcode[6:3] == 4'b1001 && !opcode[0]))
        else $error("pc select on operand a for a wrong opcode");

endmodule

// execute_unit has no clock of its own, so the top that holds it is the bind target
bind execute_stage_top execute_stage_props props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .opcode       (opcode),
    .stall_pc     (stall_pc),
    .instr_output (instr_output),
    .sel_a_in     (sel_a_in)
);

//--- testbench/execute_stage_tb.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module execute_stage_tb;

    localparam int N_INSTR = 2000;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr_in;
    logic        branch_in;
    logic [6:0]  opcode;
    logic [3:0]  rn, rs, rm;
    logic [4:0]  imm5;
    logic        branch_value;
    logic [31:0] instr_output;
    logic [1:0]  sel_a_in, sel_b_in, sel_shift_in;
    logic        sel_shift, en_a, en_b, en_s, stall_pc;

    // reference copies of the four stage words
    logic [31:0] ex_m, mem_m, wt_m, wb_m;
    logic        br_m;
    logic        checking;
    logic [42:0] exp_v;
    int          issued;
    int          cycles;

    execute_stage_top dut_i (
        .clk (clk), .arst_n (arst_n), .instr_in (instr_in), .branch_in (branch_in),
        .opcode (opcode), .rn (rn), .rs (rs), .rm (rm), .imm5 (imm5),
        .branch_value (branch_value), .instr_output (instr_output),
        .sel_a_in (sel_a_in), .sel_b_in (sel_b_in), .sel_shift_in (sel_shift_in),
        .sel_shift (sel_shift), .en_a (en_a), .en_b (en_b), .en_s (en_s),
        .stall_pc (stall_pc)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic load_op(input logic [6:0] op);
        return op[6:4] == 3'b110 || op[6:3] == 4'b1000;  // ldr, ldr literal
    endfunction

    function automatic logic [1:0] fwd_ref(input logic used, input logic [3:0] src,
                                           input logic [31:0] mem, input logic [31:0] wb);
        logic [6:0] mop;
        logic       pre;
        mop = mem[27:21];
        pre = mop[6:5] == 2'b11 && mop[2:1] == 2'b10;  // pre-indexed ldr/str
        if (!used)
            return 2'b00;
        if (mop != `EXEC_OPCODE_NOP && ((pre && src == mem[20:17]) || (!mop[6] && src == mem[16:13])))
            return 2'b01;
        if (load_op(wb[27:21]) && src == wb[16:13])
            return 2'b10;
        return 2'b00;
    endfunction

    // {sel_a, sel_b, sel_shift_in, sel_shift, en_a, en_b, en_s, stall, instr_output}
    function automatic logic [42:0] expect_outputs(input logic [31:0] ex, input logic [31:0] mem,
                                                   input logic [31:0] wt, input logic [31:0] wb);
        logic [6:0] op;
        logic       u_rn, u_rm, u_rs, stall, shf, ea, eb, es;
        logic [1:0] sa, sb, ss;
        op   = ex[27:21];
        u_rn = (!op[6] && op != `EXEC_OPCODE_NOP && op[3:0] != 4'd0) || op[6:5] == 2'b11;
        u_rm = (!op[6] && op[4]) || (op[6:5] == 2'b11 && op[3]) || (op[6:3] == 4'b1001 && op[0]);
        u_rs = op[6:4] == 3'b011;
        stall = (u_rn && ((load_op(mem[27:21]) && ex[20:17] == mem[16:13])
                      || (load_op(wt[27:21]) && ex[20:17] == wt[16:13])))
             || (u_rm && ((load_op(mem[27:21]) && ex[8:5] == mem[16:13])
                      || (load_op(wt[27:21]) && ex[8:5] == wt[16:13])))
             || (u_rs && ((load_op(mem[27:21]) && ex[12:9] == mem[16:13])
                      || (load_op(wt[27:21]) && ex[12:9] == wt[16:13])));
        sa = fwd_ref(u_rn, ex[20:17], mem, wb);
        sb = fwd_ref(u_rm, ex[8:5], mem, wb);
        ss = fwd_ref(u_rs, ex[12:9], mem, wb);
        {shf, ea, eb, es} = 4'b0000;
        if (!op[6]) begin
            if (op != `EXEC_OPCODE_NOP && op[5:4] != 2'b10 && ex[31:28] != 4'hf)
                {shf, ea, eb, es} = {op[5] & op[4], op[3], op[4], op[4]};
        end else if (op[6:5] == 2'b11 || op[6:3] == 4'b1000) begin
            if (!op[3]) begin
                ea = 1'b1;  // immediate offset
                if (op[6:3] == 4'b1000)
                    sa = 2'b11;
            end else begin
                {shf, ea, eb, es} = 4'b1111;
            end
        end else if (op[6:3] == 4'b1001) begin
            {shf, ea, eb, es} = {1'b1, 1'b0, op[0], 1'b1};
            ss = 2'b11;
            if (!op[0])
                sa = 2'b11;
        end
        return {sa, sb, ss, shf, ea, eb, es, stall, stall ? `EXEC_NOP_INSTR : ex};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [6:0]  op;
        logic [3:0]  cond;
        logic [1:0]  r0, r1, r2, r3;
        int unsigned kind;
        kind = $urandom % 9;
        op   = 7'($urandom);
        cond = ($urandom % 8 == 0) ? 4'hf : 4'he;  // some cond 1111 alu ops
        r0 = 2'($urandom);  // r0..r3 only, lots of hazards
        r1 = 2'($urandom);
        r2 = 2'($urandom);
        r3 = 2'($urandom);
        case (kind)
            0, 1, 2: op[6] = 1'b0;
            3:       return `EXEC_NOP_INSTR;
            4:       op[6:4] = 3'b110;
            5:       op[6:4] = 3'b111;
            6:       op[6:3] = 4'b1000;
            7:       op[6:3] = 4'b1001;
            default: op[6:4] = 3'b101;  // undefined group
        endcase
        return {cond, op, 2'b00, r0, 2'b00, r1, 2'b00, r2, 2'b00, r3, 5'($urandom)};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %0t ns %s is %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // reference register updates
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_m  <= `EXEC_NOP_INSTR;
            mem_m <= `EXEC_NOP_INSTR;
            wt_m  <= `EXEC_NOP_INSTR;
            wb_m  <= `EXEC_NOP_INSTR;
            br_m  <= 1'b0;
        end else begin
            wb_m  <= wt_m;
            wt_m  <= mem_m;
            mem_m <= exp_v[32] ? `EXEC_NOP_INSTR : ex_m;
            if (branch_in)
                ex_m <= `EXEC_NOP_INSTR;  // squash even when stalled
            else if (!exp_v[32])
                ex_m <= instr_in;
            br_m <= branch_in;
        end
    end

    assign exp_v = expect_outputs(ex_m, mem_m, wt_m, wb_m);

    // compare on the falling edge, everything settled
    always @(negedge clk) begin
        if (checking) begin
            check("opcode", 32'(opcode), 32'(ex_m[27:21]));
            check("rn", 32'(rn), 32'(ex_m[20:17]));
            check("rs", 32'(rs), 32'(ex_m[12:9]));
            check("rm", 32'(rm), 32'(ex_m[8:5]));
            check("imm5", 32'(imm5), 32'(ex_m[4:0]));
            check("branch_value", 32'(branch_value), 32'(br_m));
            check("sel_a_in", 32'(sel_a_in), 32'(exp_v[42:41]));
            check("sel_b_in", 32'(sel_b_in), 32'(exp_v[40:39]));
            check("sel_shift_in", 32'(sel_shift_in), 32'(exp_v[38:37]));
            check("sel_shift", 32'(sel_shift), 32'(exp_v[36]));
            check("en_a", 32'(en_a), 32'(exp_v[35]));
            check("en_b", 32'(en_b), 32'(exp_v[34]));
            check("en_s", 32'(en_s), 32'(exp_v[33]));
            check("stall_pc", 32'(stall_pc), 32'(exp_v[32]));
            check("instr_output", instr_output, exp_v[31:0]);
        end
    end

    initial begin
        void'($urandom(32'hcfc8_8806));
        clk       = 1'b0;
        arst_n    = 1'b0;
        instr_in  = `EXEC_NOP_INSTR;
        branch_in = 1'b0;
        checking  = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        while (opcode !== `EXEC_OPCODE_NOP && cycles < 5) begin  // reset release
            @(posedge clk);
            cycles++;
        end
        if (opcode !== `EXEC_OPCODE_NOP) begin
            $display("timed out waiting for the execute stage to come out of reset");
            $display("Testbench failed");
            $fatal(1);
        end
        @(negedge clk);
        // nops everywhere, every control idle
        check("reset opcode", 32'(opcode), 32'(`EXEC_OPCODE_NOP));
        check("reset instr_output", instr_output, `EXEC_NOP_INSTR);
        check("reset stall_pc", 32'(stall_pc), 32'd0);
        check("reset sel_a_in", 32'(sel_a_in), 32'd0);
        check("reset sel_b_in", 32'(sel_b_in), 32'd0);
        check("reset sel_shift_in", 32'(sel_shift_in), 32'd0);
        check("reset sel_shift", 32'(sel_shift), 32'd0);
        check("reset en_a", 32'(en_a), 32'd0);
        check("reset en_b", 32'(en_b), 32'd0);
        check("reset en_s", 32'(en_s), 32'd0);
        check("reset branch_value", 32'(branch_value), 32'd0);
        checking = 1'b1;
        issued = 0;
        cycles = 0;
        while (issued < N_INSTR && cycles < 20 * N_INSTR) begin
            @(posedge clk);
            cycles++;
            branch_in <= ($urandom % 16 == 0);
            if (!stall_pc) begin  // source holds while stalled
                instr_in <= random_instr();
                issued++;
            end
        end
        @(posedge clk);
        branch_in <= 1'b0;
        instr_in  <= `EXEC_NOP_INSTR;
        repeat (5) @(posedge clk);  // drain the pipe
        @(negedge clk);
        if (issued < N_INSTR) begin
            $display("timed out waiting for all instructions to enter execute");
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- verilog/downstream_stage_tracker.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

// memory, wait and writeback instruction registers
module downstream_stage_tracker
    import exec_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`EXEC_INSTR_W-1:0]  instr_in,            // from execute, nop on stall
    output logic [`EXEC_REG_W-1:0]    rn_memory,
    output logic [`EXEC_REG_W-1:0]    rd_memory,
    output logic [`EXEC_OPCODE_W-1:0] opcode_memory,
    output logic [1:0]                sel_w_addr1_memory,
    output logic [`EXEC_REG_W-1:0]    rt_memory_wait,
    output logic [`EXEC_OPCODE_W-1:0] opcode_memory_wait,
    output logic [`EXEC_REG_W-1:0]    rt_writeback,
    output logic [`EXEC_OPCODE_W-1:0] opcode_writeback
);

    logic [`EXEC_INSTR_W-1:0] mem_q;
    logic [`EXEC_INSTR_W-1:0] wait_q;
    logic [`EXEC_INSTR_W-1:0] wb_q;
    op_class_e                mem_cls;

    // plain shift chain, one op per stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_q  <= `EXEC_NOP_INSTR;
            wait_q <= `EXEC_NOP_INSTR;
            wb_q   <= `EXEC_NOP_INSTR;
        end else begin
            mem_q  <= instr_in;
            wait_q <= mem_q;
            wb_q   <= wait_q;
        end
    end

    // memory stage
    assign opcode_memory = mem_q[`EXEC_OPCODE_RANGE];
    assign rn_memory     = mem_q[`EXEC_RN_RANGE];
    assign rd_memory     = mem_q[`EXEC_RD_RANGE];
    assign mem_cls       = opcode_class(opcode_memory);

    // pre-indexed ldr/str updates its base in this stage
    assign sel_w_addr1_memory = ((mem_cls == op_ldr || mem_cls == op_str)
                                 && opcode_memory[2:1] == 2'b10) ? 2'b10 : 2'b00;

    // wait stage, only load target matters
    assign opcode_memory_wait = wait_q[`EXEC_OPCODE_RANGE];
    assign rt_memory_wait     = wait_q[`EXEC_RD_RANGE];

    // writeback
    assign opcode_writeback = wb_q[`EXEC_OPCODE_RANGE];
    assign rt_writeback     = wb_q[`EXEC_RD_RANGE];

endmodule

//--- verilog/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// instruction format widths
`define EXEC_INSTR_W   32
`define EXEC_OPCODE_W  7
`define EXEC_REG_W     4
`define EXEC_COND_W    4
`define EXEC_IMM_W     5

// field positions in the instruction word
`define EXEC_COND_RANGE    31:28
`define EXEC_OPCODE_RANGE  27:21
`define EXEC_RN_RANGE      20:17
`define EXEC_RD_RANGE      16:13   // rd for alu, rt for load/store
`define EXEC_RS_RANGE      12:9
`define EXEC_RM_RANGE      8:5
`define EXEC_IMM_RANGE     4:0

// nop opcode and the full nop word, all other fields zero
`define EXEC_OPCODE_NOP  7'b0100000
`define EXEC_NOP_INSTR   {4'b0000, `EXEC_OPCODE_NOP, 21'd0}

`endif

//--- verilog/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

    // opcode class from the top opcode bits
    typedef enum logic [2:0] {
        op_alu,       // 0xxxxxx
        op_nop,       // 0100000 only
        op_ldr,       // 110xxxx
        op_str,       // 111xxxx
        op_ldr_lit,   // 1000xxx
        op_branch,    // 1001xxx
        op_undef      // 101xxxx, decodes to nothing
    } op_class_e;

    // operand path select
    typedef enum logic [1:0] {
        sel_reg     = 2'b00,  // register file
        sel_fwd_alu = 2'b01,  // alu result in memory stage
        sel_fwd_mem = 2'b10,  // load data in writeback
        sel_pc_imm  = 2'b11   // pc / immediate path
    } operand_sel_e;

    function automatic op_class_e opcode_class(input logic [`EXEC_OPCODE_W-1:0] op);
        casez (op)
            `EXEC_OPCODE_NOP: return op_nop;  // must win over the alu row
            7'b0??????:       return op_alu;
            7'b110????:       return op_ldr;
            7'b111????:       return op_str;
            7'b1000???:       return op_ldr_lit;
            7'b1001???:       return op_branch;
            default:          return op_undef;
        endcase
    endfunction

    // rn read by alu ops with a nonzero low nibble, and by ldr/str
    function automatic logic uses_rn(input logic [`EXEC_OPCODE_W-1:0] op);
        op_class_e cls;
        cls = opcode_class(op);
        return (cls == op_alu && op[3:0] != 4'b0000) || cls == op_ldr || cls == op_str;
    endfunction

    function automatic logic uses_rm(input logic [`EXEC_OPCODE_W-1:0] op);
        return (!op[6] && op[4])              // alu register operand
            || (op[6:5] == 2'b11 && op[3])    // register-offset ldr/str
            || (op[6:3] == 4'b1001 && op[0]); // branch to register
    endfunction

    // register-specified shift
    function automatic logic uses_rs(input logic [`EXEC_OPCODE_W-1:0] op);
        return op[6:4] == 3'b011;
    endfunction

    function automatic logic is_load(input logic [`EXEC_OPCODE_W-1:0] op);
        op_class_e cls;
        cls = opcode_class(op);
        return cls == op_ldr || cls == op_ldr_lit;
    endfunction

    // every alu op writes rd, nop included but filtered by callers
    function automatic logic writes_rd(input logic [`EXEC_OPCODE_W-1:0] op);
        return !op[6];
    endfunction

endpackage

//--- verilog/execute_pipeline_unit.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

// execute stage instruction register
module execute_pipeline_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`EXEC_INSTR_W-1:0]  instr_in,
    input  logic                      branch_in,    // one-cycle taken-branch pulse
    input  logic                      sel_stall,    // hold, from stall_pc
    output logic [`EXEC_COND_W-1:0]   cond,
    output logic [`EXEC_OPCODE_W-1:0] opcode,
    output logic [`EXEC_REG_W-1:0]    rn,
    output logic [`EXEC_REG_W-1:0]    rd,
    output logic [`EXEC_REG_W-1:0]    rs,
    output logic [`EXEC_REG_W-1:0]    rm,
    output logic [`EXEC_IMM_W-1:0]    imm5,
    output logic                      branch_value,
    output logic [`EXEC_INSTR_W-1:0]  instr_output
);

    logic [`EXEC_INSTR_W-1:0] instr_q;  // held word
    logic                     branch_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_q  <= `EXEC_NOP_INSTR;
            branch_q <= 1'b0;
        end else begin
            branch_q <= branch_in;
            if (branch_in) begin
                instr_q <= `EXEC_NOP_INSTR;  // squash beats hold
            end else if (!sel_stall) begin
                instr_q <= instr_in;
            end
            // else keep the stalled instruction
        end
    end

    // field split
    assign cond   = instr_q[`EXEC_COND_RANGE];
    assign opcode = instr_q[`EXEC_OPCODE_RANGE];
    assign rn     = instr_q[`EXEC_RN_RANGE];
    assign rd     = instr_q[`EXEC_RD_RANGE];
    assign rs     = instr_q[`EXEC_RS_RANGE];
    assign rm     = instr_q[`EXEC_RM_RANGE];
    assign imm5   = instr_q[`EXEC_IMM_RANGE];

    assign branch_value = branch_q;
    assign instr_output = instr_q;  // whole word for the controller

endmodule

//--- verilog/execute_stage_top.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module execute_stage_top
    import exec_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`EXEC_INSTR_W-1:0]  instr_in,
    input  logic                      branch_in,
    output logic [`EXEC_OPCODE_W-1:0] opcode,
    output logic [`EXEC_REG_W-1:0]    rn,
    output logic [`EXEC_REG_W-1:0]    rs,
    output logic [`EXEC_REG_W-1:0]    rm,
    output logic [`EXEC_IMM_W-1:0]    imm5,
    output logic                      branch_value,
    output logic [`EXEC_INSTR_W-1:0]  instr_output,
    output operand_sel_e              sel_a_in,
    output operand_sel_e              sel_b_in,
    output operand_sel_e              sel_shift_in,
    output logic                      sel_shift,
    output logic                      en_a,
    output logic                      en_b,
    output logic                      en_s,
    output logic                      stall_pc
);

    logic [`EXEC_COND_W-1:0]   cond;
    logic [`EXEC_REG_W-1:0]    rd;
    logic [`EXEC_INSTR_W-1:0]  instr_held;          // execute register word
    logic [`EXEC_REG_W-1:0]    rn_memory;
    logic [`EXEC_REG_W-1:0]    rd_memory;
    logic [`EXEC_OPCODE_W-1:0] opcode_memory;
    logic [1:0]                sel_w_addr1_memory;
    logic [`EXEC_REG_W-1:0]    rt_memory_wait;
    logic [`EXEC_OPCODE_W-1:0] opcode_memory_wait;
    logic [`EXEC_REG_W-1:0]    rt_writeback;
    logic [`EXEC_OPCODE_W-1:0] opcode_writeback;

    execute_pipeline_unit execute_pipeline_unit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .sel_stall    (stall_pc),     // hold on load-use
        .cond         (cond),
        .opcode       (opcode),
        .rn           (rn),
        .rd           (rd),
        .rs           (rs),
        .rm           (rm),
        .imm5         (imm5),
        .branch_value (branch_value),
        .instr_output (instr_held)
    );

    execute_unit execute_unit_i (
        .opcode             (opcode),
        .cond               (cond),
        .rn                 (rn),
        .rd                 (rd),
        .rs                 (rs),
        .rm                 (rm),
        .instr_in           (instr_held),
        .rn_memory          (rn_memory),
        .rd_memory          (rd_memory),
        .opcode_memory      (opcode_memory),
        .sel_w_addr1_memory (sel_w_addr1_memory),
        .rt_memory_wait     (rt_memory_wait),
        .opcode_memory_wait (opcode_memory_wait),
        .rt_writeback       (rt_writeback),
        .opcode_writeback   (opcode_writeback),
        .sel_a_in           (sel_a_in),
        .sel_b_in           (sel_b_in),
        .sel_shift_in       (sel_shift_in),
        .sel_shift          (sel_shift),
        .en_a               (en_a),
        .en_b               (en_b),
        .en_s               (en_s),
        .stall_pc           (stall_pc),
        .instr_output       (instr_output)
    );

    // later stages fed from the controller output, bubbles included
    downstream_stage_tracker downstream_stage_tracker_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .instr_in           (instr_output),
        .rn_memory          (rn_memory),
        .rd_memory          (rd_memory),
        .opcode_memory      (opcode_memory),
        .sel_w_addr1_memory (sel_w_addr1_memory),
        .rt_memory_wait     (rt_memory_wait),
        .opcode_memory_wait (opcode_memory_wait),
        .rt_writeback       (rt_writeback),
        .opcode_writeback   (opcode_writeback)
    );

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

// execute stage controller, purely combinational
module execute_unit
    import exec_pkg::*;
(
    // held instruction
    input  logic [`EXEC_OPCODE_W-1:0] opcode,
    input  logic [`EXEC_COND_W-1:0]   cond,
    input  logic [`EXEC_REG_W-1:0]    rn,
    input  logic [`EXEC_REG_W-1:0]    rd,
    input  logic [`EXEC_REG_W-1:0]    rs,
    input  logic [`EXEC_REG_W-1:0]    rm,
    input  logic [`EXEC_INSTR_W-1:0]  instr_in,
    // later stages
    input  logic [`EXEC_REG_W-1:0]    rn_memory,           // pre-index base
    input  logic [`EXEC_REG_W-1:0]    rd_memory,
    input  logic [`EXEC_OPCODE_W-1:0] opcode_memory,
    input  logic [1:0]                sel_w_addr1_memory,  // 10 = pre-indexed writeback
    input  logic [`EXEC_REG_W-1:0]    rt_memory_wait,
    input  logic [`EXEC_OPCODE_W-1:0] opcode_memory_wait,
    input  logic [`EXEC_REG_W-1:0]    rt_writeback,
    input  logic [`EXEC_OPCODE_W-1:0] opcode_writeback,
    // operand path control
    output operand_sel_e              sel_a_in,
    output operand_sel_e              sel_b_in,
    output operand_sel_e              sel_shift_in,
    output logic                      sel_shift,
    output logic                      en_a,
    output logic                      en_b,
    output logic                      en_s,
    output logic                      stall_pc,
    output logic [`EXEC_INSTR_W-1:0]  instr_output  // into memory stage
);

    op_class_e    cls;            // class of held op
    logic         mem_live;       // memory stage holds a real op
    logic         mem_pre_wb;     // memory stage writes back its base
    logic         mem_wr_rd;      // memory stage writes rd
    logic         mem_load;
    logic         wait_load;
    logic         wb_load;
    operand_sel_e fwd_a;
    operand_sel_e fwd_b;
    operand_sel_e fwd_s;
    logic         hit_rn;
    logic         hit_rm;
    logic         hit_rs;

    // one source register against the later stages
    // memory stage result wins over writeback load data
    function automatic operand_sel_e fwd_select(
        input logic                   used,
        input logic [`EXEC_REG_W-1:0] src
    );
        operand_sel_e sel;
        sel = sel_reg;
        if (used) begin
            if (mem_live && ((mem_pre_wb && src == rn_memory) || (mem_wr_rd && src == rd_memory))) begin
                sel = sel_fwd_alu;
            end else if (wb_load && src == rt_writeback) begin
                sel = sel_fwd_mem;
            end
        end
        return sel;
    endfunction

    // load still in flight to src, data not ready for forwarding
    function automatic logic load_use(
        input logic                   used,
        input logic [`EXEC_REG_W-1:0] src
    );
        return used && ((mem_load && src == rd_memory) || (wait_load && src == rt_memory_wait));
    endfunction

    assign cls        = opcode_class(opcode);
    assign mem_live   = opcode_memory != `EXEC_OPCODE_NOP;
    assign mem_pre_wb = sel_w_addr1_memory == 2'b10;
    assign mem_wr_rd  = writes_rd(opcode_memory);
    assign mem_load   = is_load(opcode_memory);
    assign wait_load  = is_load(opcode_memory_wait);
    assign wb_load    = is_load(opcode_writeback);  // nop is never a load

    assign fwd_a = fwd_select(uses_rn(opcode), rn);
    assign fwd_b = fwd_select(uses_rm(opcode), rm);
    assign fwd_s = fwd_select(uses_rs(opcode), rs);

    assign hit_rn = load_use(uses_rn(opcode), rn);
    assign hit_rm = load_use(uses_rm(opcode), rm);
    assign hit_rs = load_use(uses_rs(opcode), rs);

    assign stall_pc = hit_rn | hit_rm | hit_rs;

    // bubble down the pipe while stalled
    // word rebuilt from the held fields, imm5 straight from the register
    assign instr_output = stall_pc ? `EXEC_NOP_INSTR
                                   : {cond, opcode, rn, rd, rs, rm, instr_in[`EXEC_IMM_RANGE]};

    always_comb begin
        // forwarding first, control overrides below
        sel_a_in     = fwd_a;
        sel_b_in     = fwd_b;
        sel_shift_in = fwd_s;
        sel_shift    = 1'b0;
        en_a         = 1'b0;
        en_b         = 1'b0;
        en_s         = 1'b0;

        case (cls)
            op_alu: begin
                // cond 1111 and 010xxxx leave the datapath idle
                if (opcode[5:4] != 2'b10 && cond != 4'b1111) begin
                    sel_shift = opcode[4] & opcode[5];  // shift kind only with reg operand
                    en_a      = opcode[3];
                    en_b      = opcode[4];
                    en_s      = opcode[4];
                end
            end
            op_ldr, op_str, op_ldr_lit: begin
                if (!opcode[3]) begin
                    // immediate offset
                    en_a = 1'b1;
                    if (cls == op_ldr_lit) begin
                        sel_a_in = sel_pc_imm;  // base is pc
                    end
                end else begin
                    // register offset through the shifter
                    sel_shift = 1'b1;
                    en_a      = 1'b1;
                    en_b      = 1'b1;
                    en_s      = 1'b1;
                end
            end
            op_branch: begin
                sel_shift    = 1'b1;
                sel_shift_in = sel_pc_imm;  // fixed shift for offset
                en_b         = opcode[0];   // register target
                en_s         = 1'b1;
                if (!opcode[0]) begin
                    sel_a_in = sel_pc_imm;  // pc relative
                end
            end
            default: begin
                // nop and undefined ops, defaults stand
            end
        endcase
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/execute_pipeline_unit.sv
verilog/execute_unit.sv
verilog/downstream_stage_tracker.sv
verilog/execute_stage_top.sv
testbench/execute_stage_props.sv
testbench/execute_stage_tb.sv
